// File: design/host_io_settings.svh
////////////////////////////////////////
// host command bridge widths and tags
////////////////////////////////////////

`ifndef HOST_IO_SETTINGS_SVH
`define HOST_IO_SETTINGS_SVH

// parallel link word from the I/O controller
`define HOST_WORD_W 16
// data word index, saturates at all ones
`define HOST_INDEX_W 10

`define JOY_W 32
`define STATUS_W 64

// upper nibble of the status request header
`define STATUS_REQ_TAG 4'hA

`endif

// File: design/host_io_pkg.sv
////////////////////////////////////////
// host command bridge shared types
////////////////////////////////////////

`default_nettype none

`include "host_io_settings.svh"

package host_io_pkg;

        // command word codes, first word of every frame
        typedef enum logic [`HOST_WORD_W-1:0] {
                CMD_NONE       = 16'h0000,
                CMD_CFG        = 16'h0001,
                CMD_JOY0       = 16'h0002,
                CMD_JOY1       = 16'h0003,
                CMD_KBD        = 16'h0005,
                CMD_STATUS     = 16'h001E,
                CMD_KBD_LED    = 16'h001F,
                CMD_STATUS_REQ = 16'h0029,
                CMD_MENUMASK   = 16'h002E
        } host_cmd_e;

        // one link word, seen raw or as a keyboard word
        // marker of all ones skips the rest of the frame
        typedef union packed {
                logic [`HOST_WORD_W-1:0] raw;
                struct packed {
                        logic [7:0] marker;
                        logic [7:0] scan;
                } kbd;
        } host_word_u;

endpackage

`default_nettype wire

// File: design/host_frame_if.sv
////////////////////////////////////////
// tracked frame from the link to its clients
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

interface host_frame_if;

        logic                       word_stb;
        logic [`HOST_INDEX_W-1:0]   index;
        host_io_pkg::host_cmd_e     cmd;
        host_io_pkg::host_word_u    din;
        logic                       frame_end;

        modport tracker (output word_stb, index, cmd, din, frame_end);

        modport client (input word_stb, index, cmd, din, frame_end);

endinterface

`default_nettype wire

// File: design/frame_tracker.sv
////////////////////////////////////////
// frame tracker
// latches the command word and counts data words
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module frame_tracker (
        input  wire                     clk_sys,
        input  wire                     reset,
        input  wire                     io_enable,
        input  wire                     io_strobe,
        input  wire [`HOST_WORD_W-1:0]  io_din,
        host_frame_if.tracker           frame
);

        // io_enable seen high on the previous edge
        logic frame_open;

        assign frame.word_stb  = io_enable & io_strobe;
        assign frame.din.raw   = io_din;
        assign frame.frame_end = frame_open & ~io_enable;

        always_ff @(posedge clk_sys or posedge reset) begin
                if (reset) begin
                        frame_open  <= 1'b0;
                        frame.cmd   <= host_io_pkg::CMD_NONE;
                        frame.index <= '0;
                end else begin
                        frame_open <= io_enable;
                        if (!io_enable) begin
                                frame.cmd   <= host_io_pkg::CMD_NONE;
                                frame.index <= '0;
                        end else if (io_strobe) begin
                                if (frame.index == 0)
                                        frame.cmd <= host_io_pkg::host_cmd_e'(io_din);
                                // index holds at its maximum
                                if (!(&frame.index))
                                        frame.index <= frame.index + 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

// File: design/control_regs.sv
////////////////////////////////////////
// control registers
// config, joysticks, status and status request
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module control_regs (
        input  wire                     clk_sys,
        input  wire                     reset,
        host_frame_if.client            frame,
        input  wire [`STATUS_W-1:0]     status_in,
        input  wire                     status_set,
        input  wire [`HOST_WORD_W-1:0]  status_menumask,
        output logic [1:0]              buttons,
        output logic                    forced_scandoubler,
        output logic                    direct_video,
        output logic [`JOY_W-1:0]       joystick_0,
        output logic [`JOY_W-1:0]       joystick_1,
        output logic [`STATUS_W-1:0]    status,
        output logic [`HOST_WORD_W-1:0] reply
);

        localparam int HALF = `JOY_W / 2;

        logic                   status_set_q;
        logic [3:0]             req_cnt;
        logic [`STATUS_W-1:0]   status_req;

        ////////////////////////////////////////
        // host writes
        ////////////////////////////////////////

        always_ff @(posedge clk_sys or posedge reset) begin
                if (reset) begin
                        buttons            <= '0;
                        forced_scandoubler <= 1'b0;
                        direct_video       <= 1'b0;
                        joystick_0         <= '0;
                        joystick_1         <= '0;
                        status             <= '0;
                end else if (frame.word_stb && frame.index != 0) begin
                        case (frame.cmd)
                                host_io_pkg::CMD_CFG: begin
                                        buttons            <= frame.din.raw[1:0];
                                        forced_scandoubler <= frame.din.raw[4];
                                        direct_video       <= frame.din.raw[10];
                                end
                                // first data word is the low half
                                host_io_pkg::CMD_JOY0:
                                        if (frame.index == 1)
                                                joystick_0[HALF-1:0] <= frame.din.raw;
                                        else
                                                joystick_0[`JOY_W-1:HALF] <= frame.din.raw;
                                host_io_pkg::CMD_JOY1:
                                        if (frame.index == 1)
                                                joystick_1[HALF-1:0] <= frame.din.raw;
                                        else
                                                joystick_1[`JOY_W-1:HALF] <= frame.din.raw;
                                host_io_pkg::CMD_STATUS:
                                        case (frame.index)
                                                1: status[15:0]  <= frame.din.raw;
                                                2: status[31:16] <= frame.din.raw;
                                                3: status[47:32] <= frame.din.raw;
                                                4: status[63:48] <= frame.din.raw;
                                                default: ;
                                        endcase
                                default: ;
                        endcase
                end
        end

        ////////////////////////////////////////
        // status set requests from the core
        ////////////////////////////////////////

        always_ff @(posedge clk_sys or posedge reset) begin
                if (reset) begin
                        status_set_q <= 1'b0;
                        req_cnt      <= '0;
                end else begin
                        status_set_q <= status_set;
                        if (status_set && !status_set_q)
                                req_cnt <= req_cnt + 1'b1;
                end
        end

        always_ff @(posedge clk_sys) begin
                if (status_set && !status_set_q)
                        status_req <= status_in;
        end

        // command is still on din at index 0
        always_comb begin
                reply = '0;
                if (frame.index == 0) begin
                        if (frame.din.raw == host_io_pkg::CMD_STATUS_REQ)
                                reply = {8'h00, `STATUS_REQ_TAG, req_cnt};
                end else if (frame.cmd == host_io_pkg::CMD_STATUS_REQ) begin
                        case (frame.index)
                                1: reply = status_req[15:0];
                                2: reply = status_req[31:16];
                                3: reply = status_req[47:32];
                                4: reply = status_req[63:48];
                                default: reply = '0;
                        endcase
                end else if (frame.cmd == host_io_pkg::CMD_MENUMASK && frame.index == 1) begin
                        reply = status_menumask;
                end
        end

endmodule

`default_nettype wire

// File: design/key_decoder.sv
////////////////////////////////////////
// keyboard decoder
// scan bytes to key events, LED readback
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module key_decoder (
        input  wire                     clk_sys,
        input  wire                     reset,
        host_frame_if.client            frame,
        input  wire [2:0]               ps2_kbd_led_status,
        input  wire [2:0]               ps2_kbd_led_use,
        output logic [10:0]             ps2_key,
        output logic [`HOST_WORD_W-1:0] reply
);

        // last four scan bytes, newest in the low byte
        logic [31:0] key_raw;
        logic        skip;
        logic        pressed;
        logic        extended;

        assign pressed  = key_raw[15:8] != 8'hF0;
        // release puts the E0 one byte further back
        assign extended = pressed ? (key_raw[15:8] == 8'hE0) : (key_raw[23:16] == 8'hE0);

        always_ff @(posedge clk_sys or posedge reset) begin
                if (reset) begin
                        key_raw <= '0;
                        skip    <= 1'b0;
                        ps2_key <= '0;
                end else if (frame.frame_end) begin
                        if (frame.cmd == host_io_pkg::CMD_KBD && !skip) begin
                                ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
                                // print screen press and release, pause press
                                if (key_raw == 32'hE012E07C)
                                        ps2_key[9:0] <= 10'h37C;
                                if (key_raw == 32'h7CE0F012)
                                        ps2_key[9:0] <= 10'h17C;
                                if (key_raw == 32'hF014F077)
                                        ps2_key[9:0] <= 10'h377;
                        end
                        skip <= 1'b0;
                end else if (frame.word_stb) begin
                        if (frame.index == 0) begin
                                if (frame.din.raw == host_io_pkg::CMD_KBD)
                                        key_raw <= '0;
                        end else if (frame.cmd == host_io_pkg::CMD_KBD) begin
                                if (&frame.din.kbd.marker)
                                        skip <= 1'b1;
                                else if (!skip)
                                        key_raw <= {key_raw[23:0], frame.din.kbd.scan};
                        end
                end
        end

        // LED state, emulation bit stays 0
        always_comb begin
                reply = '0;
                if (frame.index != 0 && frame.cmd == host_io_pkg::CMD_KBD_LED)
                        reply = {8'h00, 2'b01,
                                 ps2_kbd_led_status[2], ps2_kbd_led_use[2],
                                 ps2_kbd_led_status[1], ps2_kbd_led_use[1],
                                 ps2_kbd_led_status[0], ps2_kbd_led_use[0]};
        end

endmodule

`default_nettype wire

// File: design/reply_merge.sv
////////////////////////////////////////
// reply merger, link output register
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module reply_merge (
        input  wire                     clk_sys,
        input  wire                     reset,
        input  wire                     io_enable,
        input  wire                     io_strobe,
        input  wire [`HOST_WORD_W-1:0]  reply_ctrl,
        input  wire [`HOST_WORD_W-1:0]  reply_key,
        output logic [`HOST_WORD_W-1:0] io_dout
);

        // each client answers only its own commands, so OR is enough
        always_ff @(posedge clk_sys or posedge reset) begin
                if (reset)
                        io_dout <= '0;
                else if (!io_enable)
                        io_dout <= '0;
                else if (io_strobe)
                        io_dout <= reply_ctrl | reply_key;
        end

endmodule

`default_nettype wire

// File: design/host_io_bridge.sv
////////////////////////////////////////
// host command bridge top level
// I/O controller word link to core registers
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module host_io_bridge (
        input  wire                     clk_sys,
        input  wire                     reset,

        // word link from the I/O controller
        input  wire                     io_enable,
        input  wire                     io_strobe,
        input  wire [`HOST_WORD_W-1:0]  io_din,
        output logic [`HOST_WORD_W-1:0] io_dout,

        output logic [1:0]              buttons,
        output logic                    forced_scandoubler,
        output logic                    direct_video,
        output logic [`JOY_W-1:0]       joystick_0,
        output logic [`JOY_W-1:0]       joystick_1,

        output logic [`STATUS_W-1:0]    status,
        input  wire [`STATUS_W-1:0]     status_in,
        input  wire                     status_set,
        input  wire [`HOST_WORD_W-1:0]  status_menumask,

        input  wire [2:0]               ps2_kbd_led_status,
        input  wire [2:0]               ps2_kbd_led_use,
        output logic [10:0]             ps2_key
);

        logic [`HOST_WORD_W-1:0] reply_ctrl;
        logic [`HOST_WORD_W-1:0] reply_key;

        host_frame_if frame_bus ();

        frame_tracker u_tracker (
                .clk_sys   (clk_sys),
                .reset     (reset),
                .io_enable (io_enable),
                .io_strobe (io_strobe),
                .io_din    (io_din),
                .frame     (frame_bus.tracker)
        );

        control_regs u_ctrl (
                .clk_sys            (clk_sys),
                .reset              (reset),
                .frame              (frame_bus.client),
                .status_in          (status_in),
                .status_set         (status_set),
                .status_menumask    (status_menumask),
                .buttons            (buttons),
                .forced_scandoubler (forced_scandoubler),
                .direct_video       (direct_video),
                .joystick_0         (joystick_0),
                .joystick_1         (joystick_1),
                .status             (status),
                .reply              (reply_ctrl)
        );

        key_decoder u_keys (
                .clk_sys            (clk_sys),
                .reset              (reset),
                .frame              (frame_bus.client),
                .ps2_kbd_led_status (ps2_kbd_led_status),
                .ps2_kbd_led_use    (ps2_kbd_led_use),
                .ps2_key            (ps2_key),
                .reply              (reply_key)
        );

        reply_merge u_reply (
                .clk_sys    (clk_sys),
                .reset      (reset),
                .io_enable  (io_enable),
                .io_strobe  (io_strobe),
                .reply_ctrl (reply_ctrl),
                .reply_key  (reply_key),
                .io_dout    (io_dout)
        );

endmodule

`default_nettype wire

// File: verification/host_io_bridge_assert.sv
////////////////////////////////////////
// link reply and key event timing checks
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module host_io_bridge_assert (
        input wire                     clk_sys,
        input wire                     reset,
        input wire                     io_enable,
        input wire                     io_strobe,
        input wire [`HOST_WORD_W-1:0]  io_din,
        input wire [`HOST_WORD_W-1:0]  io_dout,
        input wire [10:0]              ps2_key
);

        int   fail_count = 0;
        // next strobe of the frame is the command word
        logic at_cmd;

        always_ff @(posedge clk_sys or posedge reset) begin
                if (reset)
                        at_cmd <= 1'b1;
                else if (!io_enable)
                        at_cmd <= 1'b1;
                else if (io_strobe)
                        at_cmd <= 1'b0;
        end

        a_dout_reset: assert property (@(posedge clk_sys) reset |=> io_dout == '0)
                else begin
                        fail_count = fail_count + 1;
                        $error("mismatch io_dout: 0x%0h after reset", $sampled(io_dout));
                end

        a_dout_idle: assert property (@(posedge clk_sys) disable iff (reset)
                !io_enable |=> io_dout == '0)
                else begin
                        fail_count = fail_count + 1;
                        $error("mismatch io_dout: 0x%0h after io_enable low", $sampled(io_dout));
                end

        // key events land only on the edge after io_enable falls
        a_key_timing: assert property (@(posedge clk_sys) disable iff (reset)
                ps2_key != $past(ps2_key) |-> $past(io_enable, 2) && !$past(io_enable))
                else begin
                        fail_count = fail_count + 1;
                        $error("ps2_key changed outside the cycle after a frame ended");
                end

        a_req_tag: assert property (@(posedge clk_sys) disable iff (reset)
                (io_enable && io_strobe && at_cmd && io_din == host_io_pkg::CMD_STATUS_REQ)
                |=> io_dout[7:4] == `STATUS_REQ_TAG)
                else begin
                        fail_count = fail_count + 1;
                        $error("mismatch io_dout tag: 0x%0h", $sampled(io_dout[7:4]));
                end

endmodule

bind host_io_bridge host_io_bridge_assert u_assert (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .io_enable (io_enable),
        .io_strobe (io_strobe),
        .io_din    (io_din),
        .io_dout   (io_dout),
        .ps2_key   (ps2_key)
);

`default_nettype wire

// File: verification/host_io_bridge_tb.sv
////////////////////////////////////////
// host command bridge testbench
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "host_io_settings.svh"

module host_io_bridge_tb;

        // a few hundred cycles of frames, with margin
        localparam int TIMEOUT_CYCLES = 2000;

        logic                     clk_sys;
        logic                     reset;
        logic                     io_enable;
        logic                     io_strobe;
        logic [`HOST_WORD_W-1:0]  io_din;
        logic [`HOST_WORD_W-1:0]  io_dout;
        logic [1:0]               buttons;
        logic                     forced_scandoubler;
        logic                     direct_video;
        logic [`JOY_W-1:0]        joystick_0;
        logic [`JOY_W-1:0]        joystick_1;
        logic [`STATUS_W-1:0]     status;
        logic [`STATUS_W-1:0]     status_in;
        logic                     status_set;
        logic [`HOST_WORD_W-1:0]  status_menumask;
        logic [2:0]               ps2_kbd_led_status;
        logic [2:0]               ps2_kbd_led_use;
        logic [10:0]              ps2_key;

        // words of the next frame, and io_dout after each strobe
        logic [`HOST_WORD_W-1:0]  frame_q [$];
        logic [`HOST_WORD_W-1:0]  replies [$];
        integer                   seed;
        int                       cycle_count = 0;
        logic                     key_toggle;

        host_io_bridge dut (.*);

        initial begin
                clk_sys = 1'b0;
                forever #20 clk_sys = ~clk_sys;
        end

        always @(posedge clk_sys) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES);
                        $display("TEST FAILED");
                        $fatal(1, "timeout");
                end
        end

        // stop at the first bound assertion failure
        always @(posedge clk_sys) begin
                if (dut.u_assert.fail_count != 0) begin
                        $display("%0d bound assertions failed", dut.u_assert.fail_count);
                        $display("TEST FAILED");
                        $fatal(1, "assertion failure");
                end
        end

        task automatic check_value(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
                assert (got === exp) else begin
                        $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
                        $display("TEST FAILED");
                        $fatal(1, "value check failed");
                end
        endtask

        ////////////////////////////////////////
        // frame stimulus
        ////////////////////////////////////////

        task automatic send_frame;
                int i;
                replies.delete();
                @(posedge clk_sys);
                #5;
                io_enable = 1'b1;
                for (i = 0; i < frame_q.size(); i++) begin
                        io_din    = frame_q[i];
                        io_strobe = 1'b1;
                        @(posedge clk_sys);
                        #5;
                        io_strobe = 1'b0;
                        replies.push_back(io_dout);
                end
                io_enable = 1'b0;
                io_din    = '0;
                // frame end edge, then one more for the key event
                @(posedge clk_sys);
                @(posedge clk_sys);
                #5;
                frame_q.delete();
        endtask

        // bytes are sent oldest first, count of them from the low end
        task automatic kbd_frame(input logic [63:0] bytes, input int count);
                int i;
                frame_q.push_back(host_io_pkg::CMD_KBD);
                for (i = count - 1; i >= 0; i--)
                        frame_q.push_back({8'h00, bytes[8*i +: 8]});
                send_frame();
        endtask

        task automatic check_key(input logic [9:0] code);
                key_toggle = ~key_toggle;
                check_value("ps2_key", 64'(ps2_key), 64'({key_toggle, code}));
        endtask

        task automatic pulse_status_set(input logic [63:0] value);
                status_in  = value;
                status_set = 1'b1;
                @(posedge clk_sys);
                #5;
                status_set = 1'b0;
                @(posedge clk_sys);
                #5;
        endtask

        // 01 then status and use pairs, LED 2 first
        function automatic logic [15:0] led_word(input logic [2:0] led_status,
                                                 input logic [2:0] led_use);
                logic [15:0] w;
                int          i;
                w = 16'h0040;
                for (i = 0; i < 3; i++) begin
                        w[2*i]     = led_use[i];
                        w[2*i + 1] = led_status[i];
                end
                return w;
        endfunction

        ////////////////////////////////////////
        // test sequence
        ////////////////////////////////////////

        initial begin
                logic [15:0] cfg_word;
                logic [15:0] lo;
                logic [15:0] hi;
                logic [63:0] quarters;
                logic [63:0] latest;
                logic [15:0] mask;
                int          i;
                seed               = 85;
                reset              = 1'b1;
                io_enable          = 1'b0;
                io_strobe          = 1'b0;
                io_din             = '0;
                status_in          = '0;
                status_set         = 1'b0;
                status_menumask    = '0;
                ps2_kbd_led_status = '0;
                ps2_kbd_led_use    = '0;
                key_toggle         = 1'b0;
                repeat (2) @(posedge clk_sys);
                #5;
                reset = 1'b0;

                cfg_word = 16'($random(seed));
                frame_q.push_back(host_io_pkg::CMD_CFG);
                frame_q.push_back(cfg_word);
                send_frame();
                check_value("buttons", 64'(buttons), 64'(cfg_word[1:0]));
                check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(cfg_word[4]));
                check_value("direct_video", 64'(direct_video), 64'(cfg_word[10]));

                lo = 16'($random(seed));
                hi = 16'($random(seed));
                frame_q.push_back(host_io_pkg::CMD_JOY0);
                frame_q.push_back(lo);
                frame_q.push_back(hi);
                send_frame();
                check_value("joystick_0", 64'(joystick_0), 64'({hi, lo}));
                lo = 16'($random(seed));
                hi = 16'($random(seed));
                frame_q.push_back(host_io_pkg::CMD_JOY1);
                frame_q.push_back(lo);
                frame_q.push_back(hi);
                send_frame();
                check_value("joystick_1", 64'(joystick_1), 64'({hi, lo}));

                quarters = {$random(seed), $random(seed)};
                frame_q.push_back(host_io_pkg::CMD_STATUS);
                for (i = 0; i < 4; i++)
                        frame_q.push_back(quarters[16*i +: 16]);
                send_frame();
                check_value("status", status, quarters);

                // three requests, only the last capture is read back
                for (i = 0; i < 3; i++) begin
                        latest = {$random(seed), $random(seed)};
                        pulse_status_set(latest);
                end
                frame_q.push_back(host_io_pkg::CMD_STATUS_REQ);
                for (i = 0; i < 4; i++)
                        frame_q.push_back(16'h0000);
                send_frame();
                // tag A over a count of three requests
                check_value("io_dout", 64'(replies[0]), 64'(16'h00A3));
                for (i = 0; i < 4; i++)
                        check_value("io_dout", 64'(replies[i+1]), 64'(latest[16*i +: 16]));

                mask            = 16'($random(seed));
                status_menumask = mask;
                frame_q.push_back(host_io_pkg::CMD_MENUMASK);
                frame_q.push_back(16'h0000);
                send_frame();
                check_value("io_dout", 64'(replies[1]), 64'(mask));

                kbd_frame(64'h1C, 1);
                check_key(10'h21C);
                kbd_frame(64'hF01C, 2);
                check_key(10'h01C);
                kbd_frame(64'hE0F075, 3);
                check_key(10'h175);
                // print screen press and release, then pause
                kbd_frame(64'hE012E07C, 4);
                check_key(10'h37C);
                kbd_frame(64'hE0F07CE0F012, 6);
                check_key(10'h17C);
                kbd_frame(64'hE11477E1F014F077, 8);
                check_key(10'h377);

                frame_q.push_back(host_io_pkg::CMD_KBD);
                frame_q.push_back(16'h0033);
                frame_q.push_back(16'hFF00);
                frame_q.push_back(16'h0044);
                send_frame();
                check_value("ps2_key", 64'(ps2_key), 64'({key_toggle, 10'h377}));

                ps2_kbd_led_status = 3'($random(seed));
                ps2_kbd_led_use    = 3'($random(seed));
                frame_q.push_back(host_io_pkg::CMD_KBD_LED);
                frame_q.push_back(16'h0000);
                send_frame();
                check_value("io_dout", 64'(replies[1]),
                            64'(led_word(ps2_kbd_led_status, ps2_kbd_led_use)));

                if (dut.u_assert.fail_count != 0) begin
                        $display("%0d bound assertions failed", dut.u_assert.fail_count);
                        $display("TEST FAILED");
                        $fatal(1, "assertion failures");
                end else begin
                        $display("TEST PASSED");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// File: host_io_bridge.f
+incdir+design
design/host_io_pkg.sv
design/host_frame_if.sv
design/frame_tracker.sv
design/control_regs.sv
design/key_decoder.sv
design/reply_merge.sv
design/host_io_bridge.sv
verification/host_io_bridge_assert.sv
verification/host_io_bridge_tb.sv

// File: Makefile
# Verilator build and run for the host command bridge

VERILATOR   ?= verilator
TOP         ?= host_io_bridge_tb
FILELIST    ?= host_io_bridge.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= -j 0
ERROR_LIMIT ?= 100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS ERROR_LIMIT"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT)

clean:
	rm -rf $(BUILD_DIR)
